// File: Bender.yml
package:
  name: lcd_ctrl

sources:
  - files:
      - lcd_pkg.sv
      - lcd_timer.sv
      - lcd_ctrl_fsm.sv
      - lcd_bus_drv.sv
      - lcd_top.sv
  - target: simulation
    files:
      - lcd_chk.sv
      - lcd_tb.sv

// File: filelist.f
lcd_pkg.sv
lcd_timer.sv
lcd_ctrl_fsm.sv
lcd_bus_drv.sv
lcd_top.sv
lcd_chk.sv
lcd_tb.sv

// File: lcd_bus_drv.sv
module lcd_bus_drv import lcd_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  lcd_cfg_t   cfg,
	input  lcd_xfer_t  xfer,
	input  drv_op_e    op,
	input  init_step_e step,
	input  logic       e_level,
	input  logic       load,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data
);

	lcd_xfer_t  xfer_q; // transfer held for the whole write
	lcd_xfer_t  bus_q;  // registered rs, rw and data lines
	logic [7:0] cmd;

	always_comb begin
		case (step)
			step_function: cmd = {4'b0011, cfg.two_line, cfg.font, 2'b00};
			step_display:  cmd = {5'b00001, cfg.display_on, cfg.cursor_on, cfg.blink};
			step_clear:    cmd = 8'b0000_0001;
			default:       cmd = {6'b000001, cfg.increment, cfg.shift}; // entry mode set
		endcase
	end

	always_ff @(posedge clk) begin
		if (load)
			xfer_q <= xfer;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			e     <= 1'b0;
			bus_q <= '0;
		end else begin
			e <= e_level && (op != op_none);
			case (op)
				op_init_cmd: bus_q <= '{rs: 1'b0, rw: 1'b0, data: cmd};
				op_xfer:     bus_q <= xfer_q;
				op_hold:     bus_q <= bus_q; // lines stay put around the e pulse
				default:     bus_q <= '0;
			endcase
		end
	end

	assign rs       = bus_q.rs;
	assign rw       = bus_q.rw;
	assign lcd_data = bus_q.data;

endmodule

// File: lcd_chk.sv
module lcd_chk (
	input logic       clk,
	input logic       reset,
	input logic       e,
	input logic       rs,
	input logic       rw,
	input logic [7:0] lcd_data,
	input logic       busy
);
	timeunit 1ns;
	timeprecision 100ps;

	int unsigned fail_count = 0; // failed assertions so far

	e_needs_busy: assert property (@(posedge clk) disable iff (reset) e |-> busy)
		else begin
			fail_count++;
			$error("e is high while busy is low");
		end

	busy_after_reset: assert property (@(posedge clk) reset |=> busy)
		else begin
			fail_count++;
			$error("busy is low on the cycle after reset");
		end

	// panel latches on e, so the lines must not move under it
	bus_stable_on_e: assert property (@(posedge clk) disable iff (reset)
		(e && $past(e)) |-> $stable({rs, rw, lcd_data}))
		else begin
			fail_count++;
			$error("rs, rw or lcd_data changed while e is high");
		end

endmodule

bind lcd_top lcd_chk chk_i (
	.clk      (clk),
	.reset    (reset),
	.e        (e),
	.rs       (rs),
	.rw       (rw),
	.lcd_data (lcd_data),
	.busy     (busy)
);

// File: lcd_ctrl_fsm.sv
module lcd_ctrl_fsm import lcd_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       lcd_enable,
	input  logic       done,
	output logic       start,
	output logic [9:0] duration_us,
	output drv_op_e    op,
	output init_step_e step,
	output logic       e_level,
	output logic       load,
	output logic       busy
);

	localparam logic [1:0] WR_SETUP = 2'd0;
	localparam logic [1:0] WR_HIGH  = 2'd1;
	localparam logic [1:0] WR_REST  = 2'd2;

	lcd_state_e state;
	logic       wait_ph;  // a wait is running rather than a pulse
	logic [1:0] wr_phase; // setup, high or rest of a write

	// wait after each init command
	function automatic logic [9:0] step_wait(input init_step_e s);
		case (s)
			step_function: return 10'(WAIT_FUNCTION_US);
			step_display:  return 10'(WAIT_DISPLAY_US);
			step_clear:    return 10'(WAIT_CLEAR_US);
			default:       return 10'(WAIT_ENTRY_US);
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= st_power_up;
			step     <= step_function;
			wait_ph  <= 1'b0;
			wr_phase <= WR_SETUP;
		end else begin
			case (state)
				st_power_up: begin
					if (!wait_ph) begin
						wait_ph <= 1'b1; // power-up wait started
					end else if (done) begin
						state   <= st_init;
						step    <= step_function;
						wait_ph <= 1'b0;
					end
				end
				st_init: begin
					if (done) begin
						if (!wait_ph) begin
							wait_ph <= 1'b1; // pulse over and the step's wait begins
						end else if (step == step_entry) begin
							state   <= st_idle;
							wait_ph <= 1'b0;
						end else begin
							step    <= init_step_e'(step + 1'b1);
							wait_ph <= 1'b0;
						end
					end
				end
				st_idle: begin
					if (lcd_enable) begin
						state    <= st_write;
						wr_phase <= WR_SETUP;
					end
				end
				default: begin // st_write
					if (done) begin
						if (wr_phase == WR_REST)
							state <= st_idle;
						else
							wr_phase <= wr_phase + 1'b1;
					end
				end
			endcase
		end
	end

	// timer and bus driver orders follow the registered state
	always_comb begin
		start       = 1'b0;
		duration_us = '0;
		op          = op_none;
		e_level     = 1'b0;
		load        = 1'b0;
		case (state)
			st_power_up: begin
				if (!wait_ph) begin
					start       = 1'b1;
					duration_us = 10'(POWER_UP_US);
				end else if (done) begin
					start       = 1'b1; // first command pulse
					duration_us = 10'(CMD_PULSE_US);
				end
			end
			st_init: begin
				op      = wait_ph ? op_none : op_init_cmd;
				e_level = !wait_ph;
				if (done && !wait_ph) begin
					start       = 1'b1;
					duration_us = step_wait(step);
				end else if (done && step != step_entry) begin
					start       = 1'b1; // next command pulse
					duration_us = 10'(CMD_PULSE_US);
				end
			end
			st_idle: begin
				if (lcd_enable) begin // accepted transfer
					load        = 1'b1;
					start       = 1'b1;
					duration_us = 10'(WRITE_SETUP_US);
				end
			end
			default: begin
				op      = (wr_phase == WR_SETUP) ? op_xfer : op_hold;
				e_level = (wr_phase == WR_HIGH);
				if (done && wr_phase == WR_SETUP) begin
					start       = 1'b1;
					duration_us = 10'(WRITE_HIGH_US);
				end else if (done && wr_phase == WR_HIGH) begin
					start       = 1'b1;
					duration_us = 10'(WRITE_TOTAL_US - WRITE_SETUP_US - WRITE_HIGH_US);
				end
			end
		endcase
	end

	assign busy = (state != st_idle);

endmodule

// File: lcd_pkg.sv
package lcd_pkg;

	// configuration bits in the order of the 7-bit cfg input
	typedef struct packed {
		logic two_line;   // function set N
		logic font;       // function set F
		logic display_on; // display control D
		logic cursor_on;  // display control C
		logic blink;      // display control B
		logic increment;  // entry mode I/D
		logic shift;      // entry mode S
	} lcd_cfg_t;

	// one bus transfer
	typedef struct packed {
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_xfer_t;

	typedef enum logic [1:0] {
		st_power_up,
		st_init,
		st_idle,
		st_write
	} lcd_state_e;

	typedef enum logic [1:0] {
		step_function,
		step_display,
		step_clear,
		step_entry
	} init_step_e;

	// order from the FSM to the bus driver
	typedef enum logic [1:0] {
		op_none,     // all lines low
		op_init_cmd, // command byte from step and cfg
		op_xfer,     // captured transfer
		op_hold      // keep lines as they are
	} drv_op_e;

	localparam int POWER_UP_US      = 500;
	localparam int CMD_PULSE_US     = 10;
	localparam int WAIT_FUNCTION_US = 50;
	localparam int WAIT_DISPLAY_US  = 50;
	localparam int WAIT_CLEAR_US    = 200; // clear needs the long wait
	localparam int WAIT_ENTRY_US    = 100;
	localparam int WRITE_SETUP_US   = 1;
	localparam int WRITE_HIGH_US    = 13;
	localparam int WRITE_TOTAL_US   = 50;

endpackage

// File: lcd_tb.sv
module lcd_tb import lcd_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PER_US = 2;
	localparam int N_ROWS = 9;
	localparam int TIMEOUT_CYCLES = (940 + 60 * N_ROWS) * CLK_PER_US * 2;

	typedef struct packed {
		logic            is_init;  // reset followed by the init sequence
		logic            req_busy; // extra lcd_enable while busy
		lcd_cfg_t        cfg;
		lcd_xfer_t       xfer;
		lcd_xfer_t [3:0] exp;      // expected bus per e pulse
	} stim_row_t;

	logic       clk;
	logic       reset;
	logic       lcd_enable;
	lcd_cfg_t   cfg;
	lcd_xfer_t  xfer;
	logic       e;
	logic       rs;
	logic       rw;
	logic [7:0] lcd_data;
	logic       busy;

	stim_row_t  rows [N_ROWS];
	lcd_xfer_t  cap_q[$];  // bus seen at each rising e
	int         width_q[$]; // e high cycles per pulse
	lcd_xfer_t  seen;
	logic       e_prev = 1'b0;
	int         width = 0;
	int         value_errs = 0;
	int         other_errs = 0;
	int         cycles = 0;

	lcd_top #(
		.CLK_PER_US (CLK_PER_US)
	) dut_i (
		.clk        (clk),
		.reset      (reset),
		.cfg        (cfg),
		.lcd_enable (lcd_enable),
		.xfer       (xfer),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.busy       (busy)
	);

	always #4 clk = ~clk;

	// command byte the panel should see for init step idx
	function automatic lcd_xfer_t cmd_for_step(lcd_cfg_t c, int idx);
		lcd_xfer_t x;
		x = '0;
		case (idx)
			0: x.data = {4'b0011, c.two_line, c.font, 2'b00};
			1: x.data = {5'b00001, c.display_on, c.cursor_on, c.blink};
			2: x.data = 8'h01;
			default: x.data = {6'b000001, c.increment, c.shift};
		endcase
		return x;
	endfunction

	task automatic check_xfer(string name, lcd_xfer_t got, lcd_xfer_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("Fail at %0t: %s got rs=%b rw=%b data=%h, expected rs=%b rw=%b data=%h",
				$time, name, got.rs, got.rw, got.data, exp.rs, exp.rw, exp.data);
		end
	endtask

	task automatic check_width(string name, int got, int lo, int hi);
		if (got < lo || got > hi) begin
			value_errs++;
			$display("Fail at %0t: %s got %0d, expected %0d to %0d", $time, name, got, lo, hi);
		end
	endtask

	task automatic check_level(string name, logic got, logic exp);
		if (got !== exp) begin
			value_errs++;
			$display("Fail at %0t: %s got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic build_table();
		for (int i = 0; i < N_ROWS; i++) begin
			rows[i] = '0;
			rows[i].is_init = (i == 0);
			rows[i].req_busy = (i % 3 == 0); // row 0 asks during power-up
			rows[i].cfg = 7'($urandom);
			rows[i].xfer = 10'($urandom);
			if (i == 0) begin
				for (int k = 0; k < 4; k++)
					rows[i].exp[k] = cmd_for_step(rows[i].cfg, k);
			end else begin
				rows[i].exp[0] = rows[i].xfer;
			end
		end
	endtask

	task automatic check_pulses(stim_row_t r, int n, int width_exp);
		if (cap_q.size() != n || width_q.size() != n) begin
			other_errs++;
			$display("expected %0d e pulses but saw %0d rising and %0d falling edges",
				n, cap_q.size(), width_q.size());
		end else begin
			for (int i = 0; i < n; i++) begin
				check_xfer($sformatf("bus at e pulse %0d", i), cap_q[i], r.exp[i]);
				check_width("e high cycles", width_q[i], width_exp - 1, width_exp + 1);
			end
		end
		cap_q.delete();
		width_q.delete();
	endtask

	task automatic run_init(stim_row_t r);
		int n;
		cfg = r.cfg;
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1 reset = 1'b0;
		check_level("busy", busy, 1'b1);
		n = 0;
		do begin
			@(posedge clk);
			n++;
			#1;
			if (r.req_busy && n == 10) begin
				lcd_enable = 1'b1; // must be dropped while the panel powers up
				xfer = 10'($urandom);
			end else begin
				lcd_enable = 1'b0;
			end
		end while (busy);
		check_width("cycles to busy low", n, 940 * CLK_PER_US, 940 * CLK_PER_US + 50);
		check_pulses(r, 4, 10 * CLK_PER_US);
	endtask

	task automatic run_xfer(stim_row_t r);
		lcd_xfer_t lines;
		repeat (2) @(posedge clk);
		#1;
		lines = {rs, rw, lcd_data};
		check_xfer("idle bus", lines, '0);
		xfer = r.xfer;
		lcd_enable = 1'b1;
		@(posedge clk);
		#1 lcd_enable = 1'b0;
		xfer = ~r.xfer; // captured copy has to hold
		check_level("busy", busy, 1'b1);
		if (r.req_busy) begin
			repeat (20) @(posedge clk);
			#1 lcd_enable = 1'b1;
			@(posedge clk);
			#1 lcd_enable = 1'b0;
		end
		do begin
			@(posedge clk);
			#1;
		end while (busy);
		check_pulses(r, 1, 13 * CLK_PER_US);
	endtask

	// bus monitor
	always @(posedge clk) begin
		if (e && !e_prev) begin
			seen.rs = rs;
			seen.rw = rw;
			seen.data = lcd_data;
			cap_q.push_back(seen);
			width = 0;
		end
		if (e)
			width++;
		else if (e_prev)
			width_q.push_back(width);
		e_prev = e;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
				value_errs, other_errs, dut_i.chk_i.fail_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'he441_7d75));
		clk = 1'b0;
		reset = 1'b1;
		lcd_enable = 1'b0;
		cfg = '0;
		xfer = '0;
		build_table();
		for (int i = 0; i < N_ROWS; i++) begin
			if (rows[i].is_init)
				run_init(rows[i]);
			else
				run_xfer(rows[i]);
		end
		$display("errors: %0d wrong values, %0d other failures, %0d assertion failures",
			value_errs, other_errs, dut_i.chk_i.fail_count);
		if (value_errs + other_errs + dut_i.chk_i.fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: lcd_timer.sv
module lcd_timer #(
	parameter int CLK_PER_US = 2
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  logic [9:0] duration_us,
	output logic       done
);

	localparam int PRE_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;

	logic [PRE_W-1:0] pre_cnt;  // cycles within the current microsecond
	logic [9:0]       us_cnt;   // microseconds left
	logic             active;
	logic             tick;

	assign tick = (pre_cnt == PRE_W'(CLK_PER_US - 1));
	assign done = active && tick && (us_cnt == 10'd1); // last tick of the count

	always_ff @(posedge clk) begin
		if (reset) begin
			active  <= 1'b0;
			pre_cnt <= '0;
			us_cnt  <= '0;
		end else if (start) begin // restarts a running count too
			active  <= 1'b1;
			pre_cnt <= '0;
			us_cnt  <= duration_us;
		end else if (active) begin
			pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
			if (tick) begin
				us_cnt <= us_cnt - 1'b1;
				if (us_cnt == 10'd1)
					active <= 1'b0; // back to idle after done
			end
		end
	end

endmodule

// File: lcd_top.sv
module lcd_top import lcd_pkg::*; #(
	parameter int CLK_PER_US = 2
) (
	input  logic       clk,
	input  logic       reset,
	input  lcd_cfg_t   cfg,
	input  logic       lcd_enable,
	input  lcd_xfer_t  xfer,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	logic       start;
	logic [9:0] duration_us;
	logic       done;
	drv_op_e    op;
	init_step_e step;
	logic       e_level;
	logic       load;

	lcd_ctrl_fsm ctrl_i (
		.clk         (clk),
		.reset       (reset),
		.lcd_enable  (lcd_enable),
		.done        (done),
		.start       (start),
		.duration_us (duration_us),
		.op          (op),
		.step        (step),
		.e_level     (e_level),
		.load        (load),
		.busy        (busy)
	);

	lcd_timer #(
		.CLK_PER_US (CLK_PER_US)
	) timer_i (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.duration_us (duration_us),
		.done        (done)
	);

	lcd_bus_drv drv_i (
		.clk      (clk),
		.reset    (reset),
		.cfg      (cfg),
		.xfer     (xfer),
		.op       (op),
		.step     (step),
		.e_level  (e_level),
		.load     (load),
		.e        (e),
		.rs       (rs),
		.rw       (rw),
		.lcd_data (lcd_data)
	);

endmodule
